// ==== Bender.yml ====
package:
  name: uart_rx

sources:
  - common/uart_rx_pkg.sv
  - common/rx_fifo_if.sv
  - rx_frame/rx_frame_fsm.sv
  - source/rx_fifo.sv
  - source/rx_irq_ctrl.sv
  - source/uart_rx_top.sv
  - target: simulation
    files:
      - tests/tb_clock_gen.sv
      - tests/uart_rx_assertions.sv
      - tests/uart_rx_tb.sv

// ==== common/rx_fifo_if.sv ====
// --------------------
// Links the frame receiver, the FIFO and the interrupt logic
// write is only raised while full is low, read only while empty is low
// --------------------
interface rx_fifo_if import uart_rx_pkg::*; ();

    // Write side, driven by the frame receiver
    logic        write;
    rx_entry_t   wr_data;
    logic        full;

    // Read side, head entry shown while empty is low
    logic        read;
    rx_entry_t   rd_data;
    logic        empty;

    // Number of entries currently stored
    fifo_count_t count;

    modport writer  (output write, output wr_data, input full);

    modport storage (input write, input wr_data, input read,
                     output full, output rd_data, output empty, output count);

    // The interrupt logic only watches the traffic
    modport monitor (input write, input read, input empty, input count);

    modport reader  (output read, input rd_data, input empty);

endinterface

// ==== common/uart_rx_pkg.sv ====
// --------------------
// Shared widths, codes and FIFO entry layout for the UART receiver
// FIFO_DEPTH must stay a power of two for the pointer wrap in the FIFO
// --------------------
package uart_rx_pkg;

    // Oversampling of the serial line
    localparam int OVERSAMPLE = 16;
    // Tick count at the middle of the start bit
    localparam int MID_TICK   = 7;
    localparam int FIFO_DEPTH = 32;

    typedef logic [7:0]  rx_byte_t;
    typedef logic [3:0]  tick_cnt_t;
    typedef logic [2:0]  bit_cnt_t;
    // One bit wider than the pointer so a full FIFO can be told apart
    typedef logic [5:0]  fifo_count_t;
    typedef logic [1:0]  data_width_t;
    typedef logic [1:0]  parity_mode_t;
    typedef logic        stop_bits_t;
    typedef logic [10:0] rx_entry_t;

    // Width codes, the data bit count is code plus five
    localparam data_width_t DW_5BIT = 2'd0;
    localparam data_width_t DW_6BIT = 2'd1;
    localparam data_width_t DW_7BIT = 2'd2;
    localparam data_width_t DW_8BIT = 2'd3;

    // Any code with bit 1 set disables parity
    localparam parity_mode_t PAR_EVEN = 2'd0;
    localparam parity_mode_t PAR_ODD  = 2'd1;

    localparam stop_bits_t SB_1BIT = 1'b0;
    localparam stop_bits_t SB_2BIT = 1'b1;

    // Flag positions above the data byte in a FIFO entry
    localparam int PARITY_ERR_BIT = 8;
    localparam int FRAME_ERR_BIT  = 9;
    localparam int OVERRUN_BIT    = 10;

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

endpackage

// ==== rx_frame/rx_frame_fsm.sv ====
// --------------------
// Receives one UART frame at 16 ticks per bit and writes it to the FIFO
// Frames that end while the FIFO is full are dropped, rx_done_o still pulses
// The start bit is not checked again at its middle
// --------------------
module rx_frame_fsm import uart_rx_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         enable_i,
    input  logic         ov_baud_tick_i,
    input  logic         rx_i,
    input  logic         data_ready_i,
    input  data_width_t  data_width_i,
    input  parity_mode_t parity_mode_i,
    input  stop_bits_t   stop_bits_i,
    output logic         rx_done_o,
    rx_fifo_if.writer    fifo
);

    rx_state_e state;
    tick_cnt_t tick_cnt;
    bit_cnt_t  bit_cnt;
    // Set once the first of two stop bits has been sampled
    logic      stop_cnt;

    rx_byte_t  shift_reg;
    logic      parity_bit;
    // Stays high while every stop bit sampled so far was high
    logic      stop_ok;

    logic      bit_end;
    logic      parity_en;
    logic      last_stop;
    bit_cnt_t  last_bit;
    rx_byte_t  data_aligned;
    logic      data_xor;

    // --------------------
    // Bit timing
    // --------------------

    // Sample point of a data, parity or stop bit
    assign bit_end   = ov_baud_tick_i && (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));
    assign parity_en = !parity_mode_i[1];
    // Index of the last data bit, width code plus four
    assign last_bit  = bit_cnt_t'(data_width_i) + bit_cnt_t'(4);
    // Last stop bit sample, this is where the frame ends
    assign last_stop = (state == RX_STOP) && bit_end && ((stop_bits_i == SB_1BIT) || stop_cnt);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    // A low line starts a frame
                    if (enable_i && !rx_i) begin
                        tick_cnt <= '0;
                        state    <= RX_START;
                    end
                end
                RX_START: begin
                    if (ov_baud_tick_i) begin
                        if (tick_cnt == tick_cnt_t'(MID_TICK)) begin
                            // From here on every wrap lands mid bit
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA, RX_PARITY, RX_STOP: begin
                    // The counter wraps by itself at OVERSAMPLE
                    if (ov_baud_tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                    if (bit_end) begin
                        if (state == RX_DATA) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == last_bit) begin
                                stop_cnt <= 1'b0;
                                state    <= parity_en ? RX_PARITY : RX_STOP;
                            end
                        end else if (state == RX_PARITY) begin
                            state <= RX_STOP;
                        end else if (last_stop) begin
                            state <= RX_IDLE;
                        end else begin
                            stop_cnt <= 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // --------------------
    // Data path
    // --------------------

    always_ff @(posedge clk_i) begin
        if (bit_end) begin
            if (state == RX_DATA) begin
                // LSB first, bits enter at the top and move down
                shift_reg <= {rx_i, shift_reg[7:1]};
                stop_ok   <= 1'b1;
            end
            if (state == RX_PARITY) begin
                parity_bit <= rx_i;
            end
            if (state == RX_STOP) begin
                stop_ok <= stop_ok & rx_i;
            end
        end
    end

    // Narrow frames leave the data in the upper bits of the shifter
    always_comb begin
        case (data_width_i)
            DW_5BIT: data_aligned = rx_byte_t'(shift_reg[7:3]);
            DW_6BIT: data_aligned = rx_byte_t'(shift_reg[7:2]);
            DW_7BIT: data_aligned = rx_byte_t'(shift_reg[7:1]);
            default: data_aligned = shift_reg;
        endcase
    end

    // Zero padding does not change the XOR
    assign data_xor = ^data_aligned ^ parity_bit;

    always_comb begin
        fifo.wr_data      = '0;
        fifo.wr_data[7:0] = data_aligned;
        // Even parity wants a zero XOR, odd parity a one
        if (parity_mode_i == PAR_EVEN) begin
            fifo.wr_data[PARITY_ERR_BIT] = data_xor;
        end else if (parity_mode_i == PAR_ODD) begin
            fifo.wr_data[PARITY_ERR_BIT] = !data_xor;
        end
        // The last stop bit is taken straight from the line
        fifo.wr_data[FRAME_ERR_BIT] = !(stop_ok && rx_i);
        // Previous data has not been collected yet
        fifo.wr_data[OVERRUN_BIT]   = data_ready_i;
    end

    assign rx_done_o  = last_stop;
    assign fifo.write = last_stop && !fifo.full;

endmodule

// ==== source/rx_fifo.sv ====
// --------------------
// First-word-fall-through FIFO, head entry is visible without a read
// Writes and reads are not checked against full and empty here
// --------------------
module rx_fifo import uart_rx_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    rx_fifo_if.storage fifo
);

    rx_entry_t                       mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    fifo_count_t                     count;

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk_i) begin
        if (fifo.write) begin
            mem[wr_ptr] <= fifo.wr_data;
        end
    end

    // --------------------
    // Pointers and fill level
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally since the depth is a power of two
            if (fifo.write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo.read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fifo.write, fifo.read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // Both at once keep the level
                default: count <= count;
            endcase
        end
    end

    // Head entry falls through to the read port
    assign fifo.rd_data = mem[rd_ptr];
    assign fifo.count   = count;
    assign fifo.empty   = (count == '0);
    assign fifo.full    = (count == fifo_count_t'(FIFO_DEPTH));

endmodule

// ==== source/rx_irq_ctrl.sv ====
// --------------------
// Data-ready interrupt, per frame in standard mode, by fill level in stream mode
// A stream threshold of zero stands for a full FIFO
// --------------------
module rx_irq_ctrl import uart_rx_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stream_mode_i,
    input  fifo_count_t threshold_i,
    rx_fifo_if.monitor  fifo,
    output logic        data_ready_o
);

    fifo_count_t thr_eff;
    fifo_count_t level_after_write;
    logic        going_empty;

    assign thr_eff = (threshold_i == '0) ? fifo_count_t'(FIFO_DEPTH) : threshold_i;

    // Fill level once the current write has landed
    assign level_after_write = fifo.read ? fifo.count : fifo.count + 1'b1;

    // FIFO is empty now, or the read in this cycle takes the last entry
    assign going_empty = (fifo.empty || (fifo.read && (fifo.count == fifo_count_t'(1))))
                         && !fifo.write;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_ready_o <= 1'b0;
        end else if (!stream_mode_i) begin
            // Standard mode, a read wins over a write in the same cycle
            if (fifo.read) begin
                data_ready_o <= 1'b0;
            end else if (fifo.write) begin
                data_ready_o <= 1'b1;
            end
        end else begin
            // Stream mode, stays set until the FIFO drains
            if (fifo.write && (level_after_write >= thr_eff)) begin
                data_ready_o <= 1'b1;
            end else if (going_empty) begin
                data_ready_o <= 1'b0;
            end
        end
    end

endmodule

// ==== source/uart_rx_top.sv ====
// --------------------
// UART receiver with receive FIFO and data-ready interrupt
// Data and error outputs show the head entry and are valid while fifo_empty_o is low
// fifo_read_i must only be raised while fifo_empty_o is low
// --------------------
module uart_rx_top import uart_rx_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         enable_i,
    input  logic         ov_baud_tick_i,
    input  logic         rx_i,
    input  logic         fifo_read_i,
    input  logic         stream_mode_i,
    input  fifo_count_t  threshold_i,
    input  data_width_t  data_width_i,
    input  parity_mode_t parity_mode_i,
    input  stop_bits_t   stop_bits_i,
    output rx_byte_t     rx_data_o,
    output logic         parity_error_o,
    output logic         frame_error_o,
    output logic         overrun_error_o,
    output logic         rx_done_o,
    output logic         data_ready_o,
    output logic         fifo_full_o,
    output logic         fifo_empty_o
);

    rx_fifo_if fifo_if ();

    // --------------------
    // Receive path
    // --------------------

    rx_frame_fsm u_rx_frame_fsm (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .enable_i       (enable_i),
        .ov_baud_tick_i (ov_baud_tick_i),
        .rx_i           (rx_i),
        // Pending data makes the next frame an overrun
        .data_ready_i   (data_ready_o),
        .data_width_i   (data_width_i),
        .parity_mode_i  (parity_mode_i),
        .stop_bits_i    (stop_bits_i),
        .rx_done_o      (rx_done_o),
        .fifo           (fifo_if.writer)
    );

    rx_fifo u_rx_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .fifo    (fifo_if.storage)
    );

    rx_irq_ctrl u_rx_irq_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stream_mode_i (stream_mode_i),
        .threshold_i   (threshold_i),
        .fifo          (fifo_if.monitor),
        .data_ready_o  (data_ready_o)
    );

    // --------------------
    // Read port
    // --------------------

    assign fifo_if.read    = fifo_read_i;
    assign rx_data_o       = fifo_if.rd_data[7:0];
    assign parity_error_o  = fifo_if.rd_data[PARITY_ERR_BIT];
    assign frame_error_o   = fifo_if.rd_data[FRAME_ERR_BIT];
    assign overrun_error_o = fifo_if.rd_data[OVERRUN_BIT];
    assign fifo_full_o     = fifo_if.full;
    assign fifo_empty_o    = fifo_if.empty;

endmodule

// ==== tests/tb_clock_gen.sv ====
// --------------------
// Testbench clock with period 40 and an active low reset
// Reset is held for 5 cycles and released on a falling edge
// --------------------
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        // Release away from the sampling edge
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #20 clk_o = ~clk_o;

endmodule

// ==== tests/uart_rx_assertions.sv ====
// --------------------
// Protocol assertions bound into the receiver top level
// All checks are off while rst_n_i is low
// --------------------
module uart_rx_assertions (
    input logic clk_i,
    input logic rst_n_i,
    input logic rx_done_o,
    input logic fifo_read_i,
    input logic fifo_empty_o,
    input logic fifo_full_o,
    input logic stream_mode_i,
    input logic data_ready_o
);

    int fail_cnt = 0;

    // A frame end is a single cycle pulse
    done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rx_done_o |=> !rx_done_o)
        else begin
            fail_cnt++;
            $error("rx_done_o stayed high for two cycles");
        end

    // Reads are only allowed while data is there
    read_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fifo_read_i |-> !fifo_empty_o)
        else begin
            fail_cnt++;
            $error("fifo_read_i raised on an empty FIFO");
        end

    full_empty_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(fifo_full_o && fifo_empty_o))
        else begin
            fail_cnt++;
            $error("fifo_full_o and fifo_empty_o high together");
        end

    // In standard mode only a read clears the interrupt
    ready_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!stream_mode_i && data_ready_o && !fifo_read_i) |=> data_ready_o)
        else begin
            fail_cnt++;
            $error("data_ready_o fell without a read in standard mode");
        end

endmodule

// ==== tests/uart_rx_tb.sv ====
// --------------------
// Random UART frames against a queue model of the FIFO and the interrupt
// Ticks come every 4 clocks, so one bit lasts 64 clocks
// --------------------
module uart_rx_tb import uart_rx_pkg::*; ();

    localparam int BIT_CLKS = OVERSAMPLE * 4;
    localparam int MAX_GAP  = 20;
    // Sweep, corruption, overrun pairs, stream threshold and overflow
    localparam int N_FRAMES = 24 + 16 + 8 + 8 + FIFO_DEPTH + 2;
    localparam int TIMEOUT  = 2 * N_FRAMES * (12 * BIT_CLKS + BIT_CLKS / 2 + MAX_GAP + 4);

    logic         clk;
    logic         rst_n;
    logic         enable;
    logic         tick;
    logic         rx;
    logic         fifo_read;
    logic         stream_mode;
    fifo_count_t  threshold;
    data_width_t  data_width;
    parity_mode_t parity_mode;
    stop_bits_t   stop_bits;
    rx_byte_t     rx_data;
    logic         parity_error;
    logic         frame_error;
    logic         overrun_error;
    logic         rx_done;
    logic         data_ready;
    logic         fifo_full;
    logic         fifo_empty;

    // Reference model of the FIFO contents and the interrupt line
    rx_entry_t    exp_q [$];
    int           model_count;
    logic         model_ready;
    int           eff_thr;

    logic [1:0]   tick_div;
    int           done_cnt  = 0;
    int           cycle_cnt = 0;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    uart_rx_top u_uart_rx_top (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .enable_i        (enable),
        .ov_baud_tick_i  (tick),
        .rx_i            (rx),
        .fifo_read_i     (fifo_read),
        .stream_mode_i   (stream_mode),
        .threshold_i     (threshold),
        .data_width_i    (data_width),
        .parity_mode_i   (parity_mode),
        .stop_bits_i     (stop_bits),
        .rx_data_o       (rx_data),
        .parity_error_o  (parity_error),
        .frame_error_o   (frame_error),
        .overrun_error_o (overrun_error),
        .rx_done_o       (rx_done),
        .data_ready_o    (data_ready),
        .fifo_full_o     (fifo_full),
        .fifo_empty_o    (fifo_empty)
    );

    bind uart_rx_top uart_rx_assertions u_uart_rx_assertions (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rx_done_o     (rx_done_o),
        .fifo_read_i   (fifo_read_i),
        .fifo_empty_o  (fifo_empty_o),
        .fifo_full_o   (fifo_full_o),
        .stream_mode_i (stream_mode_i),
        .data_ready_o  (data_ready_o)
    );

    // --------------------
    // Tick, frame end counter and watchdog
    // --------------------

    // One tick in every four clocks, changed on the falling edge
    always @(negedge clk) begin
        tick_div <= tick_div + 1'b1;
        tick     <= (tick_div == 2'd3);
    end

    always @(posedge clk) begin
        if (rst_n && rx_done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (u_uart_rx_top.u_uart_rx_assertions.fail_cnt != 0) begin
            $display("An assertion in the DUT failed at time %0t", $time);
            $display("tests failed");
            $fatal(1);
        end else if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT);
            $display("tests failed");
            $fatal(1);
        end
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // Called on a falling edge, returns on the falling edge one bit later
    task automatic drive_bit(input logic b);
        rx = b;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    // Serializes one frame with the current settings and waits for its end
    task automatic send_frame(input rx_byte_t data, input logic bad_par, input logic bad_stop);
        logic       par;
        logic [1:0] stop_vals;
        int         start_done;
        par = ^data;
        if (parity_mode == PAR_ODD) begin
            par = ~par;
        end
        par ^= bad_par;
        // Bit 1 is the first of two stop bits, bit 0 the last one
        stop_vals = 2'b11;
        if (bad_stop) begin
            if (stop_bits == SB_2BIT) begin
                stop_vals[$urandom_range(1, 0)] = 1'b0;
            end else begin
                stop_vals[0] = 1'b0;
            end
        end
        start_done = done_cnt;
        drive_bit(1'b0);
        for (int i = 0; i < 5 + int'(data_width); i++) begin
            drive_bit(data[i]);
        end
        if (!parity_mode[1]) begin
            drive_bit(par);
        end
        if (stop_bits == SB_2BIT) begin
            drive_bit(stop_vals[1]);
        end
        // A low last stop bit is lifted right at the frame end, no false start
        rx = stop_vals[0];
        do begin
            @(negedge clk);
        end while (done_cnt == start_done);
        rx = 1'b1;
        repeat (BIT_CLKS / 2 + $urandom_range(MAX_GAP, 1)) @(negedge clk);
    endtask

    task automatic set_random_config();
        data_width  = data_width_t'($urandom_range(3, 0));
        parity_mode = parity_mode_t'($urandom_range(3, 0));
        stop_bits   = stop_bits_t'($urandom_range(1, 0));
    endtask

    // Sends a random byte and updates the model the way the DUT should
    task automatic run_frame(input logic bad_par, input logic bad_stop);
        rx_byte_t  data;
        rx_entry_t entry;
        data  = rx_byte_t'($urandom) & (8'hFF >> (2'd3 - data_width));
        entry = '0;
        entry[7:0]            = data;
        entry[PARITY_ERR_BIT] = bad_par && !parity_mode[1];
        entry[FRAME_ERR_BIT]  = bad_stop;
        entry[OVERRUN_BIT]    = model_ready;
        send_frame(data, bad_par, bad_stop);
        // A full FIFO loses the frame
        if (model_count < FIFO_DEPTH) begin
            exp_q.push_back(entry);
            model_count++;
            if (!stream_mode || model_count >= eff_thr) begin
                model_ready = 1'b1;
            end
        end
        check_value("data_ready_o", data_ready, model_ready);
        check_value("fifo_empty_o", fifo_empty, model_count == 0);
        check_value("fifo_full_o", fifo_full, model_count == FIFO_DEPTH);
    endtask

    task automatic read_entry();
        rx_entry_t exp;
        exp = exp_q.pop_front();
        check_value("fifo_empty_o", fifo_empty, 1'b0);
        check_value("rx_data_o", rx_data, exp[7:0]);
        check_value("parity_error_o", parity_error, exp[PARITY_ERR_BIT]);
        check_value("frame_error_o", frame_error, exp[FRAME_ERR_BIT]);
        check_value("overrun_error_o", overrun_error, exp[OVERRUN_BIT]);
        fifo_read = 1'b1;
        @(negedge clk);
        fifo_read = 1'b0;
        model_count--;
        if (!stream_mode || model_count == 0) begin
            model_ready = 1'b0;
        end
        check_value("data_ready_o", data_ready, model_ready);
        check_value("fifo_empty_o", fifo_empty, model_count == 0);
    endtask

    task automatic drain_fifo();
        while (exp_q.size() > 0) begin
            read_entry();
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        void'($urandom(32'h8924));
        enable      = 1'b0;
        tick        = 1'b0;
        tick_div    = 2'd0;
        rx          = 1'b1;
        fifo_read   = 1'b0;
        stream_mode = 1'b0;
        threshold   = '0;
        data_width  = DW_8BIT;
        parity_mode = PAR_EVEN;
        stop_bits   = SB_1BIT;
        model_count = 0;
        model_ready = 1'b0;
        eff_thr     = FIFO_DEPTH;
        @(posedge rst_n);
        @(negedge clk);
        check_value("fifo_empty_o after reset", fifo_empty, 1'b1);
        check_value("data_ready_o after reset", data_ready, 1'b0);
        check_value("rx_done_o after reset", rx_done, 1'b0);
        enable = 1'b1;

        // Clean frames over every width, parity and stop setting
        for (int w = 0; w < 4; w++) begin
            for (int p = 0; p < 3; p++) begin
                for (int s = 0; s < 2; s++) begin
                    data_width  = data_width_t'(w);
                    // Both codes with the upper bit set mean no parity
                    parity_mode = (p == 2) ? parity_mode_t'($urandom_range(3, 2))
                                           : parity_mode_t'(p);
                    stop_bits   = stop_bits_t'(s);
                    run_frame(1'b0, 1'b0);
                    read_entry();
                end
            end
        end

        // Random corruption of the parity and stop bits
        repeat (16) begin
            set_random_config();
            run_frame(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
            read_entry();
        end

        // Second frame before a read is an overrun
        repeat (4) begin
            set_random_config();
            run_frame(1'b0, 1'b0);
            run_frame(1'b0, 1'b0);
            read_entry();
            read_entry();
        end

        // Stream mode with a small non-zero threshold
        stream_mode = 1'b1;
        threshold   = fifo_count_t'($urandom_range(8, 1));
        eff_thr     = int'(threshold);
        repeat (eff_thr) begin
            set_random_config();
            run_frame(1'b0, 1'b0);
        end
        drain_fifo();

        // Threshold zero waits for a full FIFO, two more frames overflow it
        threshold = '0;
        eff_thr   = FIFO_DEPTH;
        repeat (FIFO_DEPTH + 2) begin
            set_random_config();
            run_frame(1'b0, 1'b0);
        end
        drain_fifo();

        if (u_uart_rx_top.u_uart_rx_assertions.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== uart_rx_top.f ====
common/uart_rx_pkg.sv
common/rx_fifo_if.sv
rx_frame/rx_frame_fsm.sv
source/rx_fifo.sv
source/rx_irq_ctrl.sv
source/uart_rx_top.sv
tests/tb_clock_gen.sv
tests/uart_rx_assertions.sv
tests/uart_rx_tb.sv
